/* Makefile */
# Verilator build and run of the coalescer testbench

VERILATOR ?= verilator
TOP       ?= coal_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass line
run: compile
	@out="$$($(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/coal_if.sv */
////////////////////////////////////////////////////////////
// Wide memory request and response buses
// Valid/ready handshake, one word slot per lane pair
////////////////////////////////////////////////////////////

interface mem_req_if #(
    parameter int out_reqs   = 2,
    parameter int addr_width = 5,
    parameter int tag_width  = 2
);
    import coal_pkg::*;

    logic                                  valid;
    logic                                  rw;
    logic [out_reqs-1:0]                   mask;
    logic [out_reqs-1:0][word_bytes-1:0]   byteen;
    logic [out_reqs-1:0][addr_width-1:0]   addr;
    mem_word_u [out_reqs-1:0]              data;
    // Index buffer slot of a read batch
    logic [tag_width-1:0]                  tag;
    logic                                  ready;

    modport master (output valid, rw, mask, byteen, addr, data, tag, input ready);
    modport slave  (input valid, rw, mask, byteen, addr, data, tag, output ready);

endinterface

interface mem_rsp_if #(
    parameter int out_reqs  = 2,
    parameter int tag_width = 2
);
    import coal_pkg::*;

    logic                 valid;
    logic [out_reqs-1:0]  mask;
    mem_word_u [out_reqs-1:0] data;
    logic [tag_width-1:0] tag;
    logic                 ready;

    modport master (output valid, mask, data, tag, input ready);
    modport slave  (input valid, mask, data, tag, output ready);

endinterface

/* hw/coal_pkg.sv */
////////////////////////////////////////////////////////////
// Coalescer package
// Lane and memory word sizes, derived widths and the wide
// memory word seen whole or as lane words
////////////////////////////////////////////////////////////

package coal_pkg;

    // Bytes in one lane word and in one memory word
    localparam int lane_bytes = 4;
    localparam int word_bytes = 8;

    // Lanes per memory word and the offset bits that select one
    localparam int data_ratio   = word_bytes / lane_bytes;
    localparam int data_ratio_w = $clog2(data_ratio);

    typedef logic [lane_bytes*8-1:0] lane_data_t;

    // Whole view for storage and byte writes, lane view for merge and split
    typedef union packed {
        logic [word_bytes*8-1:0]     whole;
        lane_data_t [data_ratio-1:0] lane;
    } mem_word_u;

endpackage

/* hw/coal_top.sv */
////////////////////////////////////////////////////////////
// Coalescer subsystem top
// Coalescer, index buffer and wide memory on lane ports
////////////////////////////////////////////////////////////

module coal_top #(
    parameter int num_reqs   = 4,
    parameter int addr_width = 6,
    parameter int tag_width  = 4,
    parameter int queue_size = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,

    input  logic                                          in_req_valid,
    input  logic                                          in_req_rw,
    input  logic [num_reqs-1:0]                           in_req_mask,
    input  logic [num_reqs-1:0][coal_pkg::lane_bytes-1:0] in_req_byteen,
    input  logic [num_reqs-1:0][addr_width-1:0]           in_req_addr,
    input  coal_pkg::lane_data_t [num_reqs-1:0]           in_req_data,
    input  logic [tag_width-1:0]                          in_req_tag,
    output logic                                          in_req_ready,

    output logic                                          in_rsp_valid,
    output logic [num_reqs-1:0]                           in_rsp_mask,
    output coal_pkg::lane_data_t [num_reqs-1:0]           in_rsp_data,
    output logic [tag_width-1:0]                          in_rsp_tag,
    input  logic                                          in_rsp_ready
);
    import coal_pkg::*;

    localparam int out_reqs    = num_reqs / data_ratio;
    localparam int word_aw     = addr_width - data_ratio_w;
    localparam int queue_addrw = $clog2(queue_size);
    localparam int ibuf_width  = tag_width + num_reqs * (1 + data_ratio_w);

    logic                   ibuf_acquire;
    logic                   ibuf_release;
    logic                   ibuf_full;
    logic [queue_addrw-1:0] ibuf_waddr;
    logic [queue_addrw-1:0] ibuf_raddr;
    logic [ibuf_width-1:0]  ibuf_wdata;
    logic [ibuf_width-1:0]  ibuf_rdata;

    mem_req_if #(
        .out_reqs   (out_reqs),
        .addr_width (word_aw),
        .tag_width  (queue_addrw)
    ) mem_req ();

    mem_rsp_if #(
        .out_reqs  (out_reqs),
        .tag_width (queue_addrw)
    ) mem_rsp ();

    mem_coalescer #(
        .num_reqs   (num_reqs),
        .addr_width (addr_width),
        .tag_width  (tag_width),
        .queue_size (queue_size)
    ) i_coalescer (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req_valid  (in_req_valid),
        .in_req_rw     (in_req_rw),
        .in_req_mask   (in_req_mask),
        .in_req_byteen (in_req_byteen),
        .in_req_addr   (in_req_addr),
        .in_req_data   (in_req_data),
        .in_req_tag    (in_req_tag),
        .in_req_ready  (in_req_ready),
        .in_rsp_valid  (in_rsp_valid),
        .in_rsp_mask   (in_rsp_mask),
        .in_rsp_data   (in_rsp_data),
        .in_rsp_tag    (in_rsp_tag),
        .in_rsp_ready  (in_rsp_ready),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .ibuf_acquire  (ibuf_acquire),
        .ibuf_wdata    (ibuf_wdata),
        .ibuf_raddr    (ibuf_raddr),
        .ibuf_release  (ibuf_release),
        .ibuf_waddr    (ibuf_waddr),
        .ibuf_rdata    (ibuf_rdata),
        .ibuf_full     (ibuf_full)
    );

    index_buffer #(
        .data_width (ibuf_width),
        .queue_size (queue_size)
    ) i_index_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .acquire    (ibuf_acquire),
        .wdata      (ibuf_wdata),
        .waddr      (ibuf_waddr),
        .raddr      (ibuf_raddr),
        .rdata      (ibuf_rdata),
        .release_en (ibuf_release),
        .full       (ibuf_full)
    );

    wide_memory #(
        .num_reqs   (num_reqs),
        .addr_width (addr_width),
        .queue_size (queue_size)
    ) i_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

/* hw/index_buffer.sv */
////////////////////////////////////////////////////////////
// Index buffer
// Slot allocator that holds per-batch data until release
////////////////////////////////////////////////////////////

module index_buffer #(
    parameter int data_width = 16,
    parameter int queue_size = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          acquire,
    input  logic [data_width-1:0]         wdata,
    output logic [$clog2(queue_size)-1:0] waddr,
    input  logic [$clog2(queue_size)-1:0] raddr,
    output logic [data_width-1:0]         rdata,
    input  logic                          release_en,
    output logic                          full
);
    localparam int queue_addrw = $clog2(queue_size);

    logic [queue_size-1:0] free_r;
    logic [data_width-1:0] entry_r [queue_size];

    // Lowest free slot wins
    always_comb begin
        waddr = '0;
        for (int s = queue_size - 1; s >= 0; s--) begin
            if (free_r[s]) begin
                waddr = queue_addrw'(s);
            end
        end
    end

    assign full  = ~|free_r;
    assign rdata = entry_r[raddr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_r <= '1;
        end else begin
            if (release_en) begin
                free_r[raddr] <= 1'b1;
            end
            if (acquire) begin
                free_r[waddr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            entry_r[waddr] <= wdata;
        end
    end

endmodule

/* hw/mem_coalescer.sv */
////////////////////////////////////////////////////////////
// Memory request coalescer
// Groups lanes by word address into wide batches and
// splits wide read responses back into lane data
////////////////////////////////////////////////////////////

module mem_coalescer #(
    parameter int num_reqs   = 4,
    parameter int addr_width = 6,
    parameter int tag_width  = 4,
    parameter int queue_size = 4
) (
    input  logic clk,
    input  logic rst_n,

    input  logic                                         in_req_valid,
    input  logic                                         in_req_rw,
    input  logic [num_reqs-1:0]                          in_req_mask,
    input  logic [num_reqs-1:0][coal_pkg::lane_bytes-1:0] in_req_byteen,
    input  logic [num_reqs-1:0][addr_width-1:0]          in_req_addr,
    input  coal_pkg::lane_data_t [num_reqs-1:0]          in_req_data,
    input  logic [tag_width-1:0]                         in_req_tag,
    output logic                                         in_req_ready,

    output logic                                         in_rsp_valid,
    output logic [num_reqs-1:0]                          in_rsp_mask,
    output coal_pkg::lane_data_t [num_reqs-1:0]          in_rsp_data,
    output logic [tag_width-1:0]                         in_rsp_tag,
    input  logic                                         in_rsp_ready,

    mem_req_if.master mem_req,
    mem_rsp_if.slave  mem_rsp,

    output logic                                                  ibuf_acquire,
    output logic [tag_width+num_reqs*(1+coal_pkg::data_ratio_w)-1:0] ibuf_wdata,
    output logic [$clog2(queue_size)-1:0]                         ibuf_raddr,
    output logic                                                  ibuf_release,
    input  logic [$clog2(queue_size)-1:0]                         ibuf_waddr,
    input  logic [tag_width+num_reqs*(1+coal_pkg::data_ratio_w)-1:0] ibuf_rdata,
    input  logic                                                  ibuf_full
);
    import coal_pkg::*;

    localparam int out_reqs    = num_reqs / data_ratio;
    localparam int word_aw     = addr_width - data_ratio_w;
    localparam int queue_addrw = $clog2(queue_size);

    typedef enum logic {st_wait, st_send} state_e;

    state_e state_r;
    logic   out_valid_r;
    logic   [num_reqs-1:0] processed_r;

    logic                                out_rw_r;
    logic [out_reqs-1:0]                 out_mask_r;
    logic [out_reqs-1:0][word_aw-1:0]    out_addr_r;
    logic [out_reqs-1:0][word_bytes-1:0] out_byteen_r;
    mem_word_u [out_reqs-1:0]            out_data_r;
    logic [queue_addrw-1:0]              out_tag_r;

    logic [num_reqs-1:0][word_aw-1:0]      in_base;
    logic [num_reqs-1:0][data_ratio_w-1:0] in_off;
    logic [out_reqs-1:0]                   batch_valid_n, batch_valid_r;
    logic [out_reqs-1:0][word_aw-1:0]      seed_addr_n, seed_addr_r;
    logic [num_reqs-1:0]                   addr_match_n, addr_match_r;
    logic [num_reqs-1:0]                   cur_pmask;
    logic [out_reqs-1:0][word_bytes-1:0]   merged_byteen;
    mem_word_u [out_reqs-1:0]              merged_data;
    logic                                  is_last_batch;
    logic                                  out_fire;

    logic [tag_width-1:0]                  dout_tag;
    logic [num_reqs-1:0]                   dout_pmask;
    logic [num_reqs-1:0][data_ratio_w-1:0] dout_off;

    for (genvar l = 0; l < num_reqs; l++) begin : g_lane
        assign in_base[l] = in_req_addr[l][addr_width-1:data_ratio_w];
        assign in_off[l]  = in_req_addr[l][data_ratio_w-1:0];
    end

    // Seed of each slot is its lowest pending lane
    for (genvar i = 0; i < out_reqs; i++) begin : g_slot
        logic [data_ratio-1:0]   pend;
        logic [data_ratio_w-1:0] pick;

        assign pend = in_req_mask[i*data_ratio +: data_ratio]
                    & ~processed_r[i*data_ratio +: data_ratio];

        always_comb begin
            pick = '0;
            for (int j = data_ratio - 1; j >= 0; j--) begin
                if (pend[j]) begin
                    pick = data_ratio_w'(j);
                end
            end
        end

        assign batch_valid_n[i] = |pend;
        assign seed_addr_n[i]   = in_base[i*data_ratio + pick];

        for (genvar j = 0; j < data_ratio; j++) begin : g_match
            assign addr_match_n[i*data_ratio + j] = (in_base[i*data_ratio + j] == seed_addr_n[i]);
        end
    end

    assign cur_pmask     = in_req_mask & addr_match_r & ~processed_r;
    assign is_last_batch = ~|(in_req_mask & ~addr_match_r & ~processed_r);

    // Byte merge, a higher lane overwrites a lower one on the same byte
    always_comb begin
        merged_byteen = '0;
        merged_data   = '0;
        for (int l = 0; l < num_reqs; l++) begin
            if (cur_pmask[l]) begin
                for (int k = 0; k < lane_bytes; k++) begin
                    if (in_req_byteen[l][k]) begin
                        merged_byteen[l / data_ratio][in_off[l]*lane_bytes + k] = 1'b1;
                        merged_data[l / data_ratio].lane[in_off[l]][k*8 +: 8] =
                            in_req_data[l][k*8 +: 8];
                    end
                end
            end
        end
    end

    assign out_fire = out_valid_r & mem_req.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r     <= st_wait;
            out_valid_r <= 1'b0;
            processed_r <= '0;
        end else begin
            case (state_r)
                st_wait: begin
                    if (out_fire) begin
                        out_valid_r <= 1'b0;
                    end
                    // Wait for the pending batch to go out first
                    if (in_req_valid && !(out_valid_r && !out_fire) && !ibuf_full) begin
                        state_r <= st_send;
                    end
                end
                default: begin
                    state_r     <= st_wait;
                    out_valid_r <= 1'b1;
                    processed_r <= is_last_batch ? '0 : (processed_r | cur_pmask);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        addr_match_r  <= addr_match_n;
        batch_valid_r <= batch_valid_n;
        seed_addr_r   <= seed_addr_n;
        if (state_r == st_send) begin
            out_rw_r     <= in_req_rw;
            out_mask_r   <= batch_valid_r;
            out_addr_r   <= seed_addr_r;
            out_byteen_r <= merged_byteen;
            out_data_r   <= merged_data;
            out_tag_r    <= ibuf_waddr;
        end
    end

    assign in_req_ready = (state_r == st_send) & is_last_batch;

    assign mem_req.valid  = out_valid_r;
    assign mem_req.rw     = out_rw_r;
    assign mem_req.mask   = out_mask_r;
    assign mem_req.addr   = out_addr_r;
    assign mem_req.byteen = out_byteen_r;
    assign mem_req.data   = out_data_r;
    assign mem_req.tag    = out_tag_r;

    // Read batches keep tag, lane mask and offsets until their response
    assign ibuf_acquire = (state_r == st_send) & ~in_req_rw;
    assign ibuf_wdata   = {in_req_tag, cur_pmask, in_off};
    assign ibuf_raddr   = mem_rsp.tag;
    assign ibuf_release = mem_rsp.valid & mem_rsp.ready;

    assign {dout_tag, dout_pmask, dout_off} = ibuf_rdata;

    for (genvar l = 0; l < num_reqs; l++) begin : g_split
        assign in_rsp_mask[l] = mem_rsp.mask[l / data_ratio] & dout_pmask[l];
        assign in_rsp_data[l] = mem_rsp.data[l / data_ratio].lane[dout_off[l]];
    end

    assign in_rsp_valid  = mem_rsp.valid;
    assign in_rsp_tag    = dout_tag;
    assign mem_rsp.ready = in_rsp_ready;

endmodule

/* hw/wide_memory.sv */
////////////////////////////////////////////////////////////
// Banked wide memory model
// Byte-enable writes, one response per read batch
////////////////////////////////////////////////////////////

module wide_memory #(
    parameter int num_reqs   = 4,
    parameter int addr_width = 6,
    parameter int queue_size = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    mem_req_if.slave  req,
    mem_rsp_if.master rsp
);
    import coal_pkg::*;

    localparam int out_reqs    = num_reqs / data_ratio;
    localparam int word_aw     = addr_width - data_ratio_w;
    localparam int mem_depth   = 2 ** word_aw;
    localparam int queue_addrw = $clog2(queue_size);

    mem_word_u mem_r [mem_depth];

    logic                     rsp_valid_r;
    logic [out_reqs-1:0]      rsp_mask_r;
    logic [queue_addrw-1:0]   rsp_tag_r;
    mem_word_u [out_reqs-1:0] rsp_data_r;
    logic                     req_fire;

    assign req.ready = ~rsp_valid_r | rsp.ready;
    assign req_fire  = req.valid & req.ready;

    // Storage and response valid, slot 1 lands after slot 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_r <= 1'b0;
            for (int w = 0; w < mem_depth; w++) begin
                mem_r[w] <= '0;
            end
        end else begin
            if (req_fire && req.rw) begin
                for (int s = 0; s < out_reqs; s++) begin
                    for (int k = 0; k < word_bytes; k++) begin
                        if (req.mask[s] && req.byteen[s][k]) begin
                            mem_r[req.addr[s]].whole[k*8 +: 8] <= req.data[s].whole[k*8 +: 8];
                        end
                    end
                end
            end
            if (req_fire && !req.rw) begin
                rsp_valid_r <= 1'b1;
            end else if (rsp.ready) begin
                rsp_valid_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !req.rw) begin
            rsp_mask_r <= req.mask;
            rsp_tag_r  <= req.tag;
            for (int s = 0; s < out_reqs; s++) begin
                if (req.mask[s]) begin
                    rsp_data_r[s] <= mem_r[req.addr[s]];
                end
            end
        end
    end

    assign rsp.valid = rsp_valid_r;
    assign rsp.mask  = rsp_mask_r;
    assign rsp.data  = rsp_data_r;
    assign rsp.tag   = rsp_tag_r;

endmodule

/* test/coal_properties.sv */
////////////////////////////////////////////////////////////
// Coalescer handshake checks
// Bound into the coalescer, watches the wide request bus
// and the index buffer allocation
////////////////////////////////////////////////////////////

module coal_properties #(
    parameter int num_reqs   = 4,
    parameter int addr_width = 6,
    parameter int queue_size = 4,
    localparam int out_reqs  = num_reqs / coal_pkg::data_ratio,
    localparam int word_aw   = addr_width - coal_pkg::data_ratio_w
) (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic                                          out_valid,
    input logic                                          out_fire,
    input logic                                          out_rw,
    input logic [out_reqs-1:0]                           out_mask,
    input logic [out_reqs-1:0][word_aw-1:0]              out_addr,
    input logic [out_reqs-1:0][coal_pkg::word_bytes-1:0] out_byteen,
    input coal_pkg::mem_word_u [out_reqs-1:0]            out_data,
    input logic [$clog2(queue_size)-1:0]                 out_tag,
    input logic                                          ibuf_acquire,
    input logic                                          ibuf_full,
    input logic                                          in_req_ready,
    // State register, high in send
    input logic                                          send_state
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // A stalled batch keeps valid and its whole payload
    a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_fire |=> out_valid
            && $stable({out_rw, out_mask, out_addr, out_byteen, out_data, out_tag}))
        else begin
            $error("wide request dropped or changed before its transfer");
            fail_count++;
        end

    a_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_mask != '0)
        else begin
            $error("wide request valid with an empty slot mask");
            fail_count++;
        end

    a_no_acquire_full: assert property (@(posedge clk) disable iff (!rst_n)
        ibuf_acquire |-> !ibuf_full)
        else begin
            $error("index buffer allocated while full");
            fail_count++;
        end

    a_ready_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        in_req_ready |-> send_state)
        else begin
            $error("lane request accepted outside the send state");
            fail_count++;
        end

endmodule

bind mem_coalescer coal_properties #(
    .num_reqs   (num_reqs),
    .addr_width (addr_width),
    .queue_size (queue_size)
) i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_valid    (out_valid_r),
    .out_fire     (out_fire),
    .out_rw       (out_rw_r),
    .out_mask     (out_mask_r),
    .out_addr     (out_addr_r),
    .out_byteen   (out_byteen_r),
    .out_data     (out_data_r),
    .out_tag      (out_tag_r),
    .ibuf_acquire (ibuf_acquire),
    .ibuf_full    (ibuf_full),
    .in_req_ready (in_req_ready),
    .send_state   (state_r)
);

/* test/coal_tb.sv */
////////////////////////////////////////////////////////////
// Coalescer subsystem testbench
// Table of lane requests checked against a byte shadow
// memory, with random response back-pressure
////////////////////////////////////////////////////////////

module coal_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_reqs    = 4;
    localparam int addr_width  = 6;
    localparam int tag_width   = 4;
    // Two slots, so back to back reads can fill the index buffer
    localparam int queue_size  = 2;
    localparam int n_rows      = 10;
    localparam int cycle_limit = 40 * n_rows + 200;

    logic                                clk;
    logic                                rst_n;
    logic                                in_req_valid;
    logic                                in_req_rw;
    logic [num_reqs-1:0]                 in_req_mask;
    logic [num_reqs-1:0][3:0]            in_req_byteen;
    logic [num_reqs-1:0][addr_width-1:0] in_req_addr;
    logic [num_reqs-1:0][31:0]           in_req_data;
    logic [tag_width-1:0]                in_req_tag;
    logic                                in_req_ready;
    logic                                in_rsp_valid;
    logic [num_reqs-1:0]                 in_rsp_mask;
    logic [num_reqs-1:0][31:0]           in_rsp_data;
    logic [tag_width-1:0]                in_rsp_tag;
    logic                                in_rsp_ready;

    // Stimulus table, lane fields packed with lane 3 leftmost
    logic         t_rw   [n_rows];
    logic [3:0]   t_mask [n_rows];
    logic [3:0]   t_tag  [n_rows];
    logic         t_rand [n_rows];
    logic         t_pipe [n_rows];
    logic [23:0]  t_addr [n_rows];
    logic [15:0]  t_ben  [n_rows];
    logic [127:0] t_data [n_rows];
    logic [127:0] t_exp  [n_rows];

    logic [7:0]   shadow [256];
    logic [3:0]   exp_tag_q  [$];
    logic [3:0]   exp_mask_q [$];
    logic [127:0] exp_data_q [$];

    logic [15:0] lfsr;
    logic        rand_ready;
    int          cycles;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          assert_errors;

    coal_top #(
        .num_reqs   (num_reqs),
        .addr_width (addr_width),
        .tag_width  (tag_width),
        .queue_size (queue_size)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req_valid  (in_req_valid),
        .in_req_rw     (in_req_rw),
        .in_req_mask   (in_req_mask),
        .in_req_byteen (in_req_byteen),
        .in_req_addr   (in_req_addr),
        .in_req_data   (in_req_data),
        .in_req_tag    (in_req_tag),
        .in_req_ready  (in_req_ready),
        .in_rsp_valid  (in_rsp_valid),
        .in_rsp_mask   (in_rsp_mask),
        .in_rsp_data   (in_rsp_data),
        .in_rsp_tag    (in_rsp_tag),
        .in_rsp_ready  (in_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic put_row(input int r, input logic rw, input logic [3:0] mask,
                           input logic [3:0] tag, input logic rnd, input logic pipe,
                           input logic [23:0] addr, input logic [15:0] ben,
                           input logic [127:0] data, input logic [127:0] expd);
        t_rw[r]   = rw;
        t_mask[r] = mask;
        t_tag[r]  = tag;
        t_rand[r] = rnd;
        t_pipe[r] = pipe;
        t_addr[r] = addr;
        t_ben[r]  = ben;
        t_data[r] = data;
        t_exp[r]  = expd;
    endtask

    task automatic load_table();
        // Four words written whole, then read back
        put_row(0, 1'b1, 4'hF, 4'h1, 1'b0, 1'b0, {6'h07, 6'h04, 6'h03, 6'h00}, 16'hFFFF,
                {32'h44444444, 32'h33333333, 32'h22222222, 32'h11111111}, '0);
        put_row(1, 1'b0, 4'hF, 4'h2, 1'b0, 1'b0, {6'h07, 6'h04, 6'h03, 6'h00}, 16'h0000,
                '0, {32'h44444444, 32'h33333333, 32'h22222222, 32'h11111111});
        // Slot 0 shares one word, slot 1 spans two
        put_row(2, 1'b1, 4'hF, 4'h3, 1'b0, 1'b0, {6'h0D, 6'h0A, 6'h09, 6'h08}, 16'hFFFF,
                {32'hA3A3A3A3, 32'hA2A2A2A2, 32'hA1A1A1A1, 32'hA0A0A0A0}, '0);
        put_row(3, 1'b0, 4'hF, 4'h4, 1'b0, 1'b0, {6'h0D, 6'h0A, 6'h09, 6'h08}, 16'h0000,
                '0, {32'hA3A3A3A3, 32'hA2A2A2A2, 32'hA1A1A1A1, 32'hA0A0A0A0});
        // Partial bytes, lanes 2 and 3 overlap on byte 0
        put_row(4, 1'b1, 4'hF, 4'h5, 1'b0, 1'b0, {6'h04, 6'h04, 6'h00, 6'h00}, 16'h31C3,
                {32'h0000CDEF, 32'h000000AB, 32'hCAFE0000, 32'h0000BEEF}, '0);
        put_row(5, 1'b0, 4'hF, 4'h6, 1'b0, 1'b0, {6'h07, 6'h04, 6'h03, 6'h00}, 16'h0000,
                '0, {32'h44444444, 32'h3333CDEF, 32'h22222222, 32'hCAFEBEEF});
        put_row(6, 1'b0, 4'h9, 4'h7, 1'b0, 1'b0, {6'h0D, 6'h00, 6'h00, 6'h09}, 16'h0000,
                '0, {32'hA3A3A3A3, 32'h00000000, 32'h00000000, 32'hA1A1A1A1});
        // Back to back reads under random response back-pressure
        put_row(7, 1'b0, 4'hF, 4'h8, 1'b1, 1'b1, {6'h0B, 6'h0A, 6'h09, 6'h08}, 16'h0000,
                '0, {32'h00000000, 32'hA2A2A2A2, 32'hA1A1A1A1, 32'hA0A0A0A0});
        put_row(8, 1'b0, 4'hF, 4'h9, 1'b1, 1'b1, {6'h06, 6'h07, 6'h02, 6'h03}, 16'h0000,
                '0, {32'h00000000, 32'h44444444, 32'h00000000, 32'h22222222});
        put_row(9, 1'b0, 4'hF, 4'hA, 1'b1, 1'b0, {6'h04, 6'h0D, 6'h08, 6'h00}, 16'h0000,
                '0, {32'h3333CDEF, 32'hA3A3A3A3, 32'hA0A0A0A0, 32'hCAFEBEEF});
    endtask

    // Lanes update the shadow in lane order, so a higher lane wins
    task automatic issue_row(input int r);
        logic [127:0] pred;
        int           idx;
        pred = '0;
        for (int l = 0; l < num_reqs; l++) begin
            if (t_mask[r][l]) begin
                for (int k = 0; k < 4; k++) begin
                    idx = t_addr[r][l*6 +: 6] * 4 + k;
                    if (t_rw[r] && t_ben[r][l*4 + k]) begin
                        shadow[idx] = t_data[r][l*32 + k*8 +: 8];
                    end
                    pred[l*32 + k*8 +: 8] = shadow[idx];
                end
                if (!t_rw[r] && pred[l*32 +: 32] != t_exp[r][l*32 +: 32]) begin
                    other_errors++;
                    $display("table row %0d lane %0d disagrees with the shadow memory", r, l);
                end
            end
        end
        if (!t_rw[r]) begin
            exp_tag_q.push_back(t_tag[r]);
            exp_mask_q.push_back(t_mask[r]);
            exp_data_q.push_back(pred);
        end
        @(posedge clk);
        rand_ready    <= t_rand[r];
        in_req_valid  <= 1'b1;
        in_req_rw     <= t_rw[r];
        in_req_mask   <= t_mask[r];
        in_req_tag    <= t_tag[r];
        in_req_addr   <= t_addr[r];
        in_req_byteen <= t_ben[r];
        in_req_data   <= t_data[r];
        do begin
            @(negedge clk);
        end while (!in_req_ready);
        @(posedge clk);
        in_req_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // One response may cover only part of a read, the rest follows
    task automatic check_response();
        if (exp_tag_q.size() == 0) begin
            other_errors++;
            $display("response with tag 0x%0h arrived with no read outstanding", in_rsp_tag);
        end else begin
            checks++;
            if (in_rsp_tag !== exp_tag_q[0]) begin
                value_errors++;
                $display("ERROR in_rsp_tag expected 0x%0h got 0x%0h", exp_tag_q[0], in_rsp_tag);
            end
            if (in_rsp_mask == '0 || (in_rsp_mask & ~exp_mask_q[0]) != '0) begin
                value_errors++;
                $display("ERROR in_rsp_mask expected within 0x%0h got 0x%0h",
                         exp_mask_q[0], in_rsp_mask);
            end
            for (int l = 0; l < num_reqs; l++) begin
                if (in_rsp_mask[l] && exp_mask_q[0][l]) begin
                    checks++;
                    if (in_rsp_data[l] !== exp_data_q[0][l*32 +: 32]) begin
                        value_errors++;
                        $display("ERROR in_rsp_data[%0d] expected 0x%08h got 0x%08h",
                                 l, exp_data_q[0][l*32 +: 32], in_rsp_data[l]);
                    end
                end
            end
            exp_mask_q[0] = exp_mask_q[0] & ~in_rsp_mask;
            if (exp_mask_q[0] == '0) begin
                void'(exp_tag_q.pop_front());
                void'(exp_mask_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && in_rsp_valid && in_rsp_ready) begin
            check_response();
        end
    end

    always @(posedge clk) begin
        if (rand_ready) begin
            lfsr = lfsr_step(lfsr);
            in_rsp_ready <= lfsr[0];
        end else begin
            in_rsp_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        in_req_valid  = 1'b0;
        in_req_rw     = 1'b0;
        in_req_mask   = '0;
        in_req_byteen = '0;
        in_req_addr   = '0;
        in_req_data   = '0;
        in_req_tag    = '0;
        in_rsp_ready  = 1'b1;
        rand_ready    = 1'b0;
        lfsr          = 16'd21487;
        cycles        = 0;
        checks        = 0;
        value_errors  = 0;
        other_errors  = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'h00;
        end
        load_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            issue_row(r);
            if (!t_pipe[r]) begin
                wait_drain();
            end
        end
        wait_drain();
        // Idle tail catches repeated responses
        repeat (10) @(posedge clk);

        assert_errors = i_dut.i_coalescer.i_props.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
                 checks, value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/coal_pkg.sv
hw/coal_if.sv
hw/mem_coalescer.sv
hw/index_buffer.sv
hw/wide_memory.sv
hw/coal_top.sv
test/coal_properties.sv
test/coal_tb.sv
